// File: flist.f
rtl/tapdl_pkg.sv
rtl/delay_line.sv
rtl/prbs_gen.sv
rtl/tap_config.sv
rtl/delay_bank.sv
verif/delay_bank_props.sv
verif/tb_delay_bank.sv

// File: run.sh
#!/bin/sh
# Build and run the delay bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_delay_bank

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -f flist.f \
    -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build stopped with status $status"
    exit $status
fi

if [ ! -x "obj_dir/$TOP" ]; then
    echo "Simulation binary obj_dir/$TOP was not produced"
    exit 1
fi

"./obj_dir/$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

exit 0

// File: verif/tb_delay_bank.sv
`timescale 1ns/1ps

module tb_delay_bank;
    import tapdl_pkg::*;

    // About twice the cycles the full sequence needs
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int SEED           = 2275;

    logic        clk;
    logic        er;
    logic        in_valid;
    sample_vec_t in_data;
    logic        cfg_valid;
    cfg_cmd_t    cfg;
    logic        out_valid;
    sample_vec_t out_data;

    integer      seed;
    int          cycle_count;
    logic        prev_in_valid;
    bit          pair_check;

    // Reference model
    // Newest history entry sits at index 0
    logic [DATA_W-1:0] history [CHANNELS][$];
    int                mdl_len [CHANNELS];
    src_mode_t         mdl_src [CHANNELS];
    logic [15:0]       lfsr_model;
    sample_vec_t       exp_q [$];

    delay_bank UUT (
        .clk       (clk),
        .er        (er),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .cfg_valid (cfg_valid),
        .cfg       (cfg),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Left-shifting LFSR for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic void reset_model();
        for (int c = 0; c < CHANNELS; c++) begin
            history[c].delete();
            mdl_len[c] = MAX_DEPTH - 1;
            mdl_src[c] = SRC_INPUT;
        end
        lfsr_model = PRBS_SEED;
        exp_q.delete();
    endfunction

    // Expected taps for the sample just accepted
    function automatic sample_vec_t expected_output();
        sample_vec_t r;
        for (int c = 0; c < CHANNELS; c++) begin
            if (mdl_len[c] < history[c].size()) begin
                r[c] = history[c][mdl_len[c]];
            end else begin
                r[c] = '0;
            end
        end
        return r;
    endfunction

    function automatic void accept_sample(input sample_vec_t d);
        logic [DATA_W-1:0] pat;
        logic [DATA_W-1:0] lane;
        pat = lfsr_model[DATA_W-1:0];
        lfsr_model = lfsr_next(lfsr_model);
        for (int c = 0; c < CHANNELS; c++) begin
            lane = (mdl_src[c] == SRC_PRBS) ? pat : d[c];
            history[c].push_front(lane);
            if (history[c].size() > MAX_DEPTH) begin
                void'(history[c].pop_back());
            end
        end
        exp_q.push_back(expected_output());
    endfunction

    function automatic void apply_cfg(input cfg_cmd_t cmd);
        case (cmd.op)
            OP_SET_LEN: mdl_len[cmd.chan] = int'(cmd.value);
            OP_SET_SRC: mdl_src[cmd.chan] = cmd.value[0] ? SRC_PRBS : SRC_INPUT;
            OP_CLEAR:   history[cmd.chan].delete();
            default:    ;
        endcase
    endfunction

    function automatic sample_vec_t random_sample();
        integer r;
        r = $random(seed);
        return sample_vec_t'(r);
    endfunction

    function automatic int random_gap();
        integer r;
        r = $random(seed);
        return int'(r[1:0]);
    endfunction

    function automatic int random_len();
        integer r;
        r = $random(seed);
        return int'(r[3:0]);
    endfunction

    task automatic wait_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            in_valid  <= 1'b0;
            cfg_valid <= 1'b0;
        end
    endtask

    task automatic send_sample(input sample_vec_t d);
        @(posedge clk);
        in_valid  <= 1'b1;
        in_data   <= d;
        cfg_valid <= 1'b0;
        accept_sample(d);
    endtask

    // Two quiet cycles on each side keep command effects apart from data
    task automatic send_cfg(input cfg_op_t op, input int chan, input int value);
        cfg_cmd_t cmd;
        cmd.op    = op;
        cmd.chan  = CHAN_W'(chan);
        cmd.value = LEN_W'(value);
        wait_idle(2);
        @(posedge clk);
        in_valid  <= 1'b0;
        cfg_valid <= 1'b1;
        cfg       <= cmd;
        apply_cfg(cmd);
        wait_idle(2);
    endtask

    task automatic send_stream(input int count, input bit gaps);
        int gap;
        for (int i = 0; i < count; i++) begin
            send_sample(random_sample());
            if (gaps) begin
                gap = random_gap();
                wait_idle(gap);
            end
        end
    endtask

    task automatic check_output();
        sample_vec_t expected;
        assert (!(out_valid && !prev_in_valid)) else
            report_failure("out_valid went high without an accepted input sample");
        assert (!(prev_in_valid && !out_valid)) else
            report_failure("out_valid missing one cycle after an accepted input sample");
        if (out_valid) begin
            assert (exp_q.size() > 0) else
                report_failure("out_valid arrived with no expected result left");
            expected = exp_q.pop_front();
            // Both PRBS channels must carry the same byte
            if (pair_check) begin
                assert (out_data[1] == out_data[3]) else
                    report_failure($sformatf(
                        "Error at %0t: PRBS channels 1 and 3 differ, %02h and %02h",
                        $time, out_data[1], out_data[3]));
            end
            for (int c = 0; c < CHANNELS; c++) begin
                assert (out_data[c] == expected[c]) else
                    report_failure($sformatf(
                        "Error at %0t: channel %0d out_data %02h, expected %02h",
                        $time, c, out_data[c], expected[c]));
            end
        end
    endtask

    // Compare in mid cycle where DUT outputs are settled
    initial begin
        prev_in_valid = 1'b0;
        forever begin
            @(negedge clk);
            check_output();
            prev_in_valid = in_valid;
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                report_failure($sformatf(
                    "Timeout after %0d cycles, the test sequence did not finish",
                    cycle_count));
            end
        end
    end

    initial begin
        int new_len;
        seed       = SEED;
        er         = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        cfg_valid  = 1'b0;
        cfg        = '0;
        pair_check = 1'b0;
        reset_model();
        repeat (2) @(posedge clk);
        er <= 1'b0;
        wait_idle(2);

        // Reset defaults give depth 16 everywhere
        $display("Reset defaults");
        send_stream(40, 1'b0);

        $display("Per channel depths with gaps");
        send_cfg(OP_SET_LEN, 0, 0);
        send_cfg(OP_SET_LEN, 1, 4);
        send_cfg(OP_SET_LEN, 2, 8);
        send_cfg(OP_SET_LEN, 3, 15);
        send_stream(250, 1'b1);

        // Tap moves over stored entries
        $display("Length change mid stream");
        send_stream(60, 1'b1);
        send_cfg(OP_SET_LEN, 1, 13);
        send_cfg(OP_SET_LEN, 3, 2);
        new_len = random_len();
        send_cfg(OP_SET_LEN, 0, new_len);
        new_len = random_len();
        send_cfg(OP_SET_LEN, 2, new_len);
        send_stream(60, 1'b1);

        $display("PRBS source on channels 1 and 3");
        send_cfg(OP_SET_SRC, 1, 1);
        send_cfg(OP_SET_SRC, 3, 1);
        send_cfg(OP_CLEAR, 1, 0);
        send_cfg(OP_CLEAR, 3, 0);
        send_cfg(OP_SET_LEN, 1, 6);
        send_cfg(OP_SET_LEN, 3, 6);
        pair_check = 1'b1;
        send_stream(200, 1'b1);
        wait_idle(2);
        pair_check = 1'b0;

        // Cleared line reads zero until refilled
        $display("Clear on channel 2");
        send_cfg(OP_SET_LEN, 2, 15);
        send_stream(30, 1'b1);
        send_cfg(OP_CLEAR, 2, 0);
        send_stream(50, 1'b1);

        wait_idle(4);
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d expected outputs never appeared", exp_q.size()));
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: verif/delay_bank_props.sv
`timescale 1ns/1ps

module delay_bank_props (
    input logic                   clk,
    input logic                   er,
    input logic                   in_valid,
    input logic                   out_valid,
    input tapdl_pkg::sample_vec_t out_data
);

    // Output stays quiet during reset
    a_quiet_in_reset : assert property (
        @(posedge clk) er |-> !out_valid
    ) else $error("out_valid is high while er is asserted");

    // Fixed one cycle latency from strobe to result
    a_one_cycle_latency : assert property (
        @(posedge clk) disable iff (er) out_valid == $past(in_valid)
    ) else $error("out_valid does not follow in_valid by one cycle");

    a_known_data : assert property (
        @(posedge clk) out_valid |-> !$isunknown(out_data)
    ) else $error("out_data has unknown bits while out_valid is high");

endmodule

bind delay_bank delay_bank_props u_props (
    .clk       (clk),
    .er        (er),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_data  (out_data)
);

// File: rtl/delay_bank.sv
`timescale 1ns/1ps

module delay_bank (
    input  logic                   clk,
    input  logic                   er,
    input  logic                   in_valid,
    input  tapdl_pkg::sample_vec_t in_data,
    input  logic                   cfg_valid,
    input  tapdl_pkg::cfg_cmd_t    cfg,
    output logic                   out_valid,
    output tapdl_pkg::sample_vec_t out_data
);
    import tapdl_pkg::*;

    logic [CHANNELS-1:0][LEN_W-1:0] chan_len;
    src_mode_t [CHANNELS-1:0]       chan_src;
    logic [CHANNELS-1:0]            chan_clear;
    logic [DATA_W-1:0]              prbs_byte;
    sample_vec_t                    lane_in;
    sample_vec_t                    tap;

    tap_config u_config (
        .clk        (clk),
        .er         (er),
        .cfg_valid  (cfg_valid),
        .cfg        (cfg),
        .chan_len   (chan_len),
        .chan_src   (chan_src),
        .chan_clear (chan_clear)
    );

    // Pattern advances once per accepted sample
    prbs_gen u_prbs (
        .clk       (clk),
        .er        (er),
        .step      (in_valid),
        .prbs_byte (prbs_byte)
    );

    for (genvar c = 0; c < CHANNELS; c++) begin : g_chan
        // Every PRBS channel gets the same byte in a cycle
        assign lane_in[c] = (chan_src[c] == SRC_PRBS) ? prbs_byte : in_data[c];

        delay_line #(
            .DEPTH (MAX_DEPTH)
        ) u_line (
            .clk   (clk),
            .er    (er),
            .shift (in_valid),
            .clear (chan_clear[c]),
            .din   (lane_in[c]),
            .len   (chan_len[c]),
            .dout  (tap[c])
        );
    end

    // One cycle of output latency
    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= tap;
        end
    end

endmodule

// File: rtl/tap_config.sv
`timescale 1ns/1ps

module tap_config (
    input  logic                                                 clk,
    input  logic                                                 er,
    input  logic                                                 cfg_valid,
    input  tapdl_pkg::cfg_cmd_t                                  cfg,
    output logic [tapdl_pkg::CHANNELS-1:0][tapdl_pkg::LEN_W-1:0] chan_len,
    output tapdl_pkg::src_mode_t [tapdl_pkg::CHANNELS-1:0]       chan_src,
    output logic [tapdl_pkg::CHANNELS-1:0]                       chan_clear
);
    import tapdl_pkg::*;

    logic [CHANNELS-1:0] chan_sel;
    logic                set_len;
    logic                set_src;
    logic                do_clear;

    // One-hot channel select
    always_comb begin
        chan_sel = '0;
        chan_sel[cfg.chan] = 1'b1;
    end

    // Opcode decode, unknown opcodes do nothing
    always_comb begin
        set_len  = 1'b0;
        set_src  = 1'b0;
        do_clear = 1'b0;
        if (cfg_valid) begin
            case (cfg.op)
                OP_SET_LEN: set_len  = 1'b1;
                OP_SET_SRC: set_src  = 1'b1;
                OP_CLEAR:   do_clear = 1'b1;
                default:    ;
            endcase
        end
    end

    // Length and source per channel
    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            for (int c = 0; c < CHANNELS; c++) begin
                chan_len[c] <= '1;
                chan_src[c] <= SRC_INPUT;
            end
        end else begin
            for (int c = 0; c < CHANNELS; c++) begin
                if (set_len && chan_sel[c]) begin
                    chan_len[c] <= cfg.value;
                end
                if (set_src && chan_sel[c]) begin
                    chan_src[c] <= src_mode_t'(cfg.value[0]);
                end
            end
        end
    end

    // Clear is a single-cycle pulse after the command
    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            chan_clear <= '0;
        end else if (do_clear) begin
            chan_clear <= chan_sel;
        end else begin
            chan_clear <= '0;
        end
    end

endmodule

// File: rtl/prbs_gen.sv
`timescale 1ns/1ps

module prbs_gen (
    input  logic                         clk,
    input  logic                         er,
    input  logic                         step,
    output logic [tapdl_pkg::DATA_W-1:0] prbs_byte
);
    import tapdl_pkg::*;

    logic [$bits(PRBS_SEED)-1:0] state_q;
    logic                        feedback;

    // x^16 + x^14 + x^13 + x^11 + 1
    assign feedback = state_q[15] ^ state_q[13] ^ state_q[12] ^ state_q[10];

    // Nonzero seed, so the all-zero lockup state is never reached
    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            state_q <= PRBS_SEED;
        end else if (step) begin
            state_q <= {state_q[14:0], feedback};
        end
    end

    // Byte before the step goes out with the current sample
    assign prbs_byte = state_q[DATA_W-1:0];

endmodule

// File: rtl/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
    parameter int DEPTH = tapdl_pkg::MAX_DEPTH
) (
    input  logic                         clk,
    input  logic                         er,
    input  logic                         shift,
    input  logic                         clear,
    input  logic [tapdl_pkg::DATA_W-1:0] din,
    input  logic [tapdl_pkg::LEN_W-1:0]  len,
    output logic [tapdl_pkg::DATA_W-1:0] dout
);
    import tapdl_pkg::*;

    logic [DEPTH-1:0][DATA_W-1:0] line_q;
    logic [DEPTH-1:0][DATA_W-1:0] line_d;

    if (DEPTH < 2) begin : g_depth_check
        $error("delay_line needs a DEPTH of at least 2");
    end

    // Next contents, clear wins over shift
    always_comb begin
        if (clear) begin
            line_d = '0;
        end else if (shift) begin
            line_d = {line_q[DEPTH-2:0], din};
        end else begin
            line_d = line_q;
        end
    end

    always_ff @(posedge clk or posedge er) begin
        if (er) begin
            line_q <= '0;
        end else begin
            line_q <= line_d;
        end
    end

    // Tap looks through to the contents after this edge, so a
    // length code of 0 returns the sample being accepted
    always_comb begin
        if (int'(len) < DEPTH) begin
            dout = line_d[len];
        end else begin
            // Codes past a short line stick to its last entry
            dout = line_d[DEPTH-1];
        end
    end

endmodule

// File: rtl/tapdl_pkg.sv
package tapdl_pkg;

    // Bank geometry
    localparam int CHANNELS  = 4;
    localparam int DATA_W    = 8;
    localparam int MAX_DEPTH = 16;

    // A length code holds the depth minus one
    localparam int LEN_W     = 4;
    localparam int CHAN_W    = 2;

    // LFSR state after reset
    localparam logic [15:0] PRBS_SEED = 16'hACE1;

    // Configuration command opcodes
    typedef enum logic [1:0] {
        OP_SET_LEN = 2'd0,
        OP_SET_SRC = 2'd1,
        OP_CLEAR   = 2'd2
    } cfg_op_t;

    // Where a channel takes its samples from
    typedef enum logic {
        SRC_INPUT = 1'b0,
        SRC_PRBS  = 1'b1
    } src_mode_t;

    // One configuration command
    // value is a length code for OP_SET_LEN
    // Bit 0 of value is the source mode for OP_SET_SRC
    typedef struct packed {
        cfg_op_t           op;
        logic [CHAN_W-1:0] chan;
        logic [LEN_W-1:0]  value;
    } cfg_cmd_t;

    // One sample lane per channel
    typedef logic [CHANNELS-1:0][DATA_W-1:0] sample_vec_t;

endpackage
